// ==== tb.f ====
+incdir+include
hw/uart_line_pkg.sv
hw/uart_data_pkg.sv
hw/uart_baud_tick.sv
hw/uart_rx.sv
hw/uart_fifo.sv
hw/uart_tx.sv
hw/uart_echo_top.sv
sim/tb_uart_echo.sv

// ==== sim/tb_uart_echo.sv ====
`timescale 1ns/10ps

`include "uart_defines.svh"

module tb_uart_echo;

    import uart_data_pkg::*;

    localparam int BIT_CYC   = `UART_OVERSAMPLE * `UART_TICK_DIV;
    localparam int FRAME_CYC = 10 * BIT_CYC;
    localparam int DEPTH     = 1 << `UART_FIFO_AW;

    logic                   clk;
    logic                   reset;
    logic                   rx_line;
    logic                   cts;
    logic                   tx_line;
    logic [7:0]             leds;
    uart_status_t           status;

    logic [7:0]             rx_q[$];  // Bytes decoded from tx_line
    logic [7:0]             exp_q[$]; // Expected echo order
    uart_status_t           exp_st;
    logic [7:0]             last_good;
    logic [`UART_FIFO_AW:0] held;     // Model FIFO occupancy while cts is low
    integer                 seed;

    uart_echo_top i_uart_echo_top (
        .clk     (clk),
        .reset   (reset),
        .rx_line (rx_line),
        .cts     (cts),
        .tx_line (tx_line),
        .leds    (leds),
        .status  (status)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("Test failures found");
        $fatal(1);
    endtask

    // Expected echo and status for one frame on rx_line
    function automatic void predict_frame(input logic [7:0] data, input bit stop_ok,
                                          input bit cts_high);
        if (!stop_ok) begin
            exp_st.frame_err = 1'b1;
        end else begin
            last_good = data;
            if (cts_high) begin
                exp_q.push_back(data);
            end else if (held < DEPTH) begin
                held++;
                exp_q.push_back(data);
            end else begin
                exp_st.overrun = 1'b1; // FIFO full, byte lost
            end
        end
        exp_st.fifo_level = held;
    endfunction

    task automatic send_frame(input logic [7:0] data, input bit stop_ok);
        logic [9:0] bits;
        bits = {stop_ok, data, 1'b0};
        @(posedge clk);
        for (int i = 0; i < 10; i++) begin
            rx_line <= bits[i];
            repeat (BIT_CYC) @(posedge clk);
        end
        rx_line <= 1'b1;
    endtask

    task automatic send_glitch(input int low_cycles);
        @(posedge clk);
        rx_line <= 1'b0;
        repeat (low_cycles) @(posedge clk);
        rx_line <= 1'b1;
        repeat (BIT_CYC) @(posedge clk);
    endtask

    task automatic expect_line_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            if (tx_line !== 1'b1)
                report_failure($sformatf("FAIL tx_line got %h expected 1", tx_line));
        end
        if (rx_q.size() != 0)
            report_failure("A byte was echoed on tx_line where none was expected");
    endtask

    task automatic check_byte(input logic [7:0] exp);
        logic [7:0] got;
        int         waited;
        waited = 0;
        while (rx_q.size() == 0 && waited < 3 * FRAME_CYC) begin
            @(posedge clk);
            waited++;
        end
        if (rx_q.size() == 0) begin
            report_failure("No echoed byte arrived on tx_line before the timeout");
        end else begin
            got = rx_q.pop_front();
            if (got !== exp)
                report_failure($sformatf("FAIL tx_line byte got %h expected %h", got, exp));
        end
    endtask

    task automatic check_leds(input logic [7:0] exp);
        for (int i = 0; i < 2 * BIT_CYC; i++) begin
            @(posedge clk);
            if (leds === exp)
                break;
        end
        if (leds !== exp)
            report_failure($sformatf("FAIL leds got %h expected %h", leds, exp));
    endtask

    task automatic check_status(input uart_status_t exp);
        for (int i = 0; i < 2 * BIT_CYC; i++) begin
            @(posedge clk);
            if (status === exp)
                break;
        end
        if (status !== exp)
            report_failure($sformatf("FAIL status got %h expected %h", status, exp));
    endtask

    // Serial decoder on tx_line, samples at mid-bit
    initial begin : tx_decoder
        logic [7:0] b;
        forever begin
            @(posedge clk);
            if (reset === 1'b0 && tx_line === 1'b0) begin
                repeat (BIT_CYC / 2) @(posedge clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT_CYC) @(posedge clk);
                    b[i] = tx_line;
                end
                repeat (BIT_CYC) @(posedge clk);
                if (tx_line !== 1'b1)
                    report_failure("An echoed frame on tx_line had a low stop bit");
                else
                    rx_q.push_back(b);
            end
        end
    end

    initial begin : main_seq
        logic [7:0] data;
        seed      = 32'ha7f7_7cfe;
        exp_st    = '0;
        held      = '0;
        last_good = 8'h00;
        reset   <= 1'b1;
        rx_line <= 1'b1;
        cts     <= 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // Idle after reset
        expect_line_idle(4 * BIT_CYC);
        check_leds(8'h00);
        check_status(exp_st);

        for (int n = 0; n < 20; n++) begin
            data = 8'($random(seed));
            send_frame(data, 1'b1);
            predict_frame(data, 1'b1, 1'b1);
            check_byte(exp_q.pop_front());
            check_leds(last_good);
            check_status(exp_st);
        end

        // Low stop bit
        data = 8'($random(seed));
        send_frame(data, 1'b0);
        predict_frame(data, 1'b0, 1'b1);
        expect_line_idle(2 * FRAME_CYC);
        check_leds(last_good);
        check_status(exp_st);

        // Glitch shorter than half a bit
        send_glitch(BIT_CYC / 4);
        exp_st.false_start = 1'b1;
        expect_line_idle(FRAME_CYC);
        check_leds(last_good);
        check_status(exp_st);
        data = 8'($random(seed));
        send_frame(data, 1'b1);
        predict_frame(data, 1'b1, 1'b1);
        check_byte(exp_q.pop_front());
        check_leds(last_good);
        check_status(exp_st);

        // Hold the transmitter and overfill the FIFO
        @(posedge clk);
        cts <= 1'b0;
        for (int n = 0; n < DEPTH + 3; n++) begin
            data = 8'($random(seed));
            send_frame(data, 1'b1);
            predict_frame(data, 1'b1, 1'b0);
            check_status(exp_st);
        end
        check_leds(last_good);
        @(posedge clk);
        cts <= 1'b1;
        held = '0;
        exp_st.fifo_level = '0;
        for (int n = 0; n < DEPTH; n++)
            check_byte(exp_q.pop_front());
        expect_line_idle(2 * FRAME_CYC);
        check_status(exp_st);

        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== hw/uart_echo_top.sv ====
`timescale 1ns/10ps

`include "uart_defines.svh"

module uart_echo_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        rx_line,
    input  logic                        cts,
    output logic                        tx_line,
    output logic [7:0]                  leds,
    output uart_data_pkg::uart_status_t status
);

    import uart_data_pkg::*;

    logic                   tick;
    logic                   rx_valid;
    logic                   rx_false_start;
    logic                   false_start_sticky;
    logic                   frame_err_sticky;
    rx_word_t               rx_word;
    logic                   push;
    logic                   pop;
    logic                   empty;
    logic [7:0]             rd_data;
    logic [`UART_FIFO_AW:0] level;
    logic                   overrun;

    uart_baud_tick i_uart_baud_tick (
        .clk   (clk),
        .reset (reset),
        .tick  (tick)
    );

    uart_rx i_uart_rx (
        .clk              (clk),
        .reset            (reset),
        .tick             (tick),
        .rx_line          (rx_line),
        .rx_valid         (rx_valid),
        .false_start      (rx_false_start),
        .rx_word          (rx_word),
        .leds             (leds),
        .frame_err_sticky (frame_err_sticky)
    );

    // Framed-bad bytes never reach the FIFO
    assign push = rx_valid & ~rx_word.framing_err;

    uart_fifo i_uart_fifo (
        .clk     (clk),
        .reset   (reset),
        .push    (push),
        .pop     (pop),
        .wr_data (rx_word.data),
        .rd_data (rd_data),
        .empty   (empty),
        .level   (level),
        .overrun (overrun)
    );

    uart_tx i_uart_tx (
        .clk     (clk),
        .reset   (reset),
        .tick    (tick),
        .cts     (cts),
        .empty   (empty),
        .rd_data (rd_data),
        .pop     (pop),
        .tx_line (tx_line)
    );

    always_ff @(posedge clk) begin
        if (reset)
            false_start_sticky <= 1'b0;
        else if (rx_false_start)
            false_start_sticky <= 1'b1;
    end

    assign status.frame_err   = frame_err_sticky;
    assign status.overrun     = overrun;
    assign status.false_start = false_start_sticky;
    assign status.fifo_level  = level;

endmodule

// ==== hw/uart_tx.sv ====
`timescale 1ns/10ps

`include "uart_defines.svh"

module uart_tx (
    input  logic       clk,
    input  logic       reset,
    input  logic       tick,
    input  logic       cts,
    input  logic       empty,
    input  logic [7:0] rd_data,
    output logic       pop,
    output logic       tx_line
);

    import uart_line_pkg::*;

    localparam int TCW = $clog2(`UART_OVERSAMPLE);
    localparam logic [TCW-1:0] LAST_TICK = TCW'(`UART_OVERSAMPLE - 1);

    tx_state_e      state;
    logic [TCW-1:0] tick_cnt;
    logic [2:0]     bit_cnt;
    logic [7:0]     shift;

    // Take the head byte on a tick so the start bit begins on tick boundary
    assign pop = (state == TX_IDLE) & tick & cts & ~empty;

    always_ff @(posedge clk) begin
        if (pop)
            shift <= rd_data;
        else if (tick && tick_cnt == LAST_TICK && state inside {TX_START, TX_DATA})
            shift <= {1'b1, shift[7:1]};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= TX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            tx_line  <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    tx_line <= 1'b1;
                    if (pop) begin
                        state    <= TX_START;
                        tick_cnt <= '0;
                        tx_line  <= 1'b0; // Start bit
                    end
                end
                TX_START: begin
                    if (tick) begin
                        if (tick_cnt == LAST_TICK) begin
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                            tx_line  <= shift[0];
                            state    <= TX_DATA;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                TX_DATA: begin
                    if (tick) begin
                        if (tick_cnt == LAST_TICK) begin
                            tick_cnt <= '0;
                            if (bit_cnt == 3'd7) begin
                                tx_line <= 1'b1; // Stop bit
                                state   <= TX_STOP;
                            end else begin
                                tx_line <= shift[0];
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                TX_STOP: begin
                    if (tick) begin
                        if (tick_cnt == LAST_TICK) begin
                            tick_cnt <= '0;
                            state    <= TX_IDLE;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    a_idle_high: assert property (@(posedge clk) disable iff (reset)
        state == TX_IDLE |-> tx_line);

endmodule

// ==== hw/uart_fifo.sv ====
`timescale 1ns/10ps

`include "uart_defines.svh"

module uart_fifo (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    push,
    input  logic                    pop,
    input  logic [7:0]              wr_data,
    output logic [7:0]              rd_data,
    output logic                    empty,
    output logic [`UART_FIFO_AW:0]  level,
    output logic                    overrun
);

    localparam int AW = `UART_FIFO_AW;
    localparam int DEPTH = 1 << AW;

    logic [7:0]    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          full;
    logic          do_push;
    logic          do_pop;

    assign full    = (count == (AW+1)'(DEPTH));
    assign empty   = (count == '0);
    assign do_pop  = pop & ~empty;
    assign do_push = push & (~full | do_pop); // Full is fine if the head leaves

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            overrun <= 1'b0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
            if (push && !do_push)
                overrun <= 1'b1; // Byte dropped
        end
    end

    assign rd_data = mem[rd_ptr];
    assign level   = count;

    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        !(pop && empty));

endmodule

// ==== hw/uart_rx.sv ====
`timescale 1ns/10ps

`include "uart_defines.svh"

module uart_rx (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     tick,
    input  logic                     rx_line,
    output logic                     rx_valid,
    output logic                     false_start,
    output uart_data_pkg::rx_word_t  rx_word,
    output logic [7:0]               leds,
    output logic                     frame_err_sticky
);

    import uart_line_pkg::*;
    import uart_data_pkg::*;

    localparam int TCW = $clog2(`UART_OVERSAMPLE);
    localparam logic [TCW-1:0] LAST_TICK = TCW'(`UART_OVERSAMPLE - 1);
    localparam logic [TCW-1:0] MID_TICK = TCW'(`UART_OVERSAMPLE / 2 - 1);

    rx_state_e      state;
    logic           rx_meta;
    logic           rx_sync;
    logic           rx_prev;
    logic           fall_edge;
    logic [TCW-1:0] tick_cnt;
    logic [2:0]     bit_cnt;
    logic [7:0]     shift;

    // Two-flop synchronizer, idle level is high
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_line;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign fall_edge = rx_prev & ~rx_sync;

    always_ff @(posedge clk) begin
        if (reset) begin
            state            <= RX_IDLE;
            tick_cnt         <= '0;
            bit_cnt          <= '0;
            rx_valid         <= 1'b0;
            false_start      <= 1'b0;
            leds             <= '0;
            frame_err_sticky <= 1'b0;
        end else begin
            rx_valid    <= 1'b0;
            false_start <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (fall_edge) begin
                        state    <= RX_START;
                        tick_cnt <= '0;
                    end
                end
                RX_START: begin
                    if (tick) begin
                        if (tick_cnt == MID_TICK) begin
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                            if (rx_sync) begin // Glitch, not a real start bit
                                state       <= RX_IDLE;
                                false_start <= 1'b1;
                            end else begin
                                state <= RX_DATA;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                RX_DATA: begin
                    if (tick) begin
                        if (tick_cnt == LAST_TICK) begin
                            tick_cnt <= '0;
                            shift    <= {rx_sync, shift[7:1]}; // LSB first
                            if (bit_cnt == 3'd7)
                                state <= RX_STOP;
                            else
                                bit_cnt <= bit_cnt + 1'b1;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                RX_STOP: begin
                    if (tick) begin
                        if (tick_cnt == LAST_TICK) begin
                            tick_cnt            <= '0;
                            state               <= RX_IDLE;
                            rx_valid            <= 1'b1;
                            rx_word.data        <= shift;
                            rx_word.framing_err <= ~rx_sync;
                            if (rx_sync)
                                leds <= shift; // Only good bytes reach the LEDs
                            else
                                frame_err_sticky <= 1'b1;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    a_valid_single: assert property (@(posedge clk) disable iff (reset)
        rx_valid |=> !rx_valid);

    a_start_on_edge: assert property (@(posedge clk) disable iff (reset)
        (state == RX_IDLE && !$fell(rx_sync)) |=> state == RX_IDLE);

endmodule

// ==== hw/uart_baud_tick.sv ====
`timescale 1ns/10ps

`include "uart_defines.svh"

module uart_baud_tick (
    input  logic clk,
    input  logic reset,
    output logic tick
);

    localparam int CW = $clog2(`UART_TICK_DIV + 1);
    localparam logic [CW-1:0] LAST = CW'(`UART_TICK_DIV - 1);

    logic [CW-1:0] div_cnt;

    // Free running, never restarted by the line
    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            if (div_cnt == LAST) begin
                div_cnt <= '0;
                tick    <= 1'b1;
            end else begin
                div_cnt <= div_cnt + 1'b1;
                tick    <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/uart_data_pkg.sv ====
`include "uart_defines.svh"

package uart_data_pkg;

    // One received frame
    typedef struct packed {
        logic [7:0] data;
        logic       framing_err; // Stop bit sampled low
    } rx_word_t;

    // Sticky error flags plus current FIFO occupancy
    typedef struct packed {
        logic                    frame_err;
        logic                    overrun;
        logic                    false_start;
        logic [`UART_FIFO_AW:0]  fifo_level;
    } uart_status_t;

endpackage

// ==== hw/uart_line_pkg.sv ====
package uart_line_pkg;

    // Receiver frame phases
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    // Transmitter frame phases
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

endpackage

// ==== include/uart_defines.svh ====
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// clk cycles per oversample tick, 4 gives 64 cycles per bit
`define UART_TICK_DIV 4

// Ticks per bit
`define UART_OVERSAMPLE 16

// FIFO address width, depth is 2**AW
`define UART_FIFO_AW 3

`endif
